//--- logic/channel_accumulator.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module channel_accumulator (
	input  logic           clk,
	input  logic           reset,
	input  logic           part_valid,
	input  conv_pkg::acc_t part_sum,
	output conv_pkg::acc_t chan_sum,
	output logic           chan_valid
);
	import conv_pkg::*;

	localparam int POS_W = $clog2(`CONV_OUT_PLANE);
	localparam int CH_W  = $clog2(`CONV_CH_IN);

	acc_t             plane_buf [0:`CONV_OUT_PLANE-1];
	logic [POS_W-1:0] pos_cnt;
	logic [CH_W-1:0]  ch_cnt;
	acc_t             run_sum;
	logic             first_ch;
	logic             last_ch;

	assign first_ch = (ch_cnt == '0);
	assign last_ch  = (ch_cnt == CH_W'(`CONV_CH_IN - 1));
	assign run_sum  = plane_buf[pos_cnt] + part_sum;

	//////////////////////////////////////////////////
	// Partial plane buffer
	//////////////////////////////////////////////////

	// First channel overwrites the stale plane
	always_ff @(posedge clk) begin
		if (part_valid) begin
			if (first_ch) begin
				plane_buf[pos_cnt] <= part_sum;
			end else begin
				plane_buf[pos_cnt] <= run_sum;
			end
		end
	end

	always_ff @(posedge clk) begin
		chan_sum <= first_ch ? part_sum : run_sum;
	end

	// Position within plane, then input channel
	always_ff @(posedge clk) begin
		if (reset) begin
			pos_cnt    <= '0;
			ch_cnt     <= '0;
			chan_valid <= 1'b0;
		end else begin
			chan_valid <= part_valid && last_ch;
			if (part_valid) begin
				if (pos_cnt == POS_W'(`CONV_OUT_PLANE - 1)) begin
					pos_cnt <= '0;
					ch_cnt  <= last_ch ? '0 : ch_cnt + 1'b1;
				end else begin
					pos_cnt <= pos_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- logic/channel_interleaver.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module channel_interleaver (
	input  logic           clk,
	input  logic           reset,
	input  logic           chan_valid,
	input  conv_pkg::acc_t chan_sum,
	output conv_pkg::acc_t pxl_out,
	output logic           valid_out
);
	import conv_pkg::*;

	localparam int DEPTH = `CONV_OUT_PLANE * `CONV_CH_OUT;
	localparam int AW    = $clog2(DEPTH);
	localparam int POS_W = $clog2(`CONV_OUT_PLANE);
	localparam int CH_W  = $clog2(`CONV_CH_OUT);

	acc_t             out_mem [0:DEPTH-1];
	logic [AW-1:0]    wr_addr;
	logic [AW-1:0]    rd_addr;
	logic [POS_W-1:0] drain_pos;
	logic [CH_W-1:0]  drain_ch;
	drain_state_t     state;

	// Planes are stored back to back, read across them per pixel
	assign rd_addr = AW'(drain_ch * `CONV_OUT_PLANE + drain_pos);

	always_ff @(posedge clk) begin
		if ((state == DS_FILL) && chan_valid) begin
			out_mem[wr_addr] <= chan_sum;
		end
	end

	always_ff @(posedge clk) begin
		pxl_out <= out_mem[rd_addr];
	end

	//////////////////////////////////////////////////
	// Fill / drain control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= DS_FILL;
			wr_addr   <= '0;
			drain_pos <= '0;
			drain_ch  <= '0;
			valid_out <= 1'b0;
		end else begin
			case (state)
				DS_FILL: begin
					valid_out <= 1'b0;
					if (chan_valid) begin
						if (wr_addr == AW'(DEPTH - 1)) begin
							wr_addr <= '0;
							state   <= DS_DRAIN;
						end else begin
							wr_addr <= wr_addr + 1'b1;
						end
					end
				end
				DS_DRAIN: begin
					valid_out <= 1'b1;
					if (drain_ch == CH_W'(`CONV_CH_OUT - 1)) begin
						drain_ch <= '0;
						if (drain_pos == POS_W'(`CONV_OUT_PLANE - 1)) begin
							drain_pos <= '0;
							state     <= DS_FILL;
						end else begin
							drain_pos <= drain_pos + 1'b1;
						end
					end else begin
						drain_ch <= drain_ch + 1'b1;
					end
				end
				default: state <= DS_FILL;
			endcase
		end
	end

endmodule

//--- logic/conv_defs.svh
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

//////////////////////////////////////////////////
// Word widths
//////////////////////////////////////////////////

// Pixels and weights
`define CONV_DATA_W 8
// Holds 9 taps x 2 channels x 16384
`define CONV_ACC_W 24

//////////////////////////////////////////////////
// Image and channel sizes
//////////////////////////////////////////////////

`define CONV_IMG_W 6
`define CONV_IMG_H 6
`define CONV_CH_IN 2
`define CONV_CH_OUT 3

// Valid convolution, no padding
`define CONV_OUT_W (`CONV_IMG_W - 2)
`define CONV_OUT_H (`CONV_IMG_H - 2)

`define CONV_PLANE (`CONV_IMG_W * `CONV_IMG_H)
`define CONV_FRAME (`CONV_PLANE * `CONV_CH_IN)
`define CONV_OUT_PLANE (`CONV_OUT_W * `CONV_OUT_H)
`define CONV_TAPS 9

`endif

//--- logic/conv_layer_3x3.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_layer_3x3 (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  conv_pkg::pixel_t  pxl_in,
	input  logic              valid_weight_in,
	input  conv_pkg::weight_t weight_in,
	output conv_pkg::acc_t    pxl_out,
	output logic              valid_out
);
	import conv_pkg::*;

	pixel_t replay_pxl;
	logic   replay_valid;
	acc_t   part_sum;
	logic   part_valid;
	acc_t   chan_sum;
	logic   chan_valid;

	//////////////////////////////////////////////////
	// Replay, convolve, sum channels, interleave
	//////////////////////////////////////////////////

	feature_replay i_feature_replay (
		.clk          (clk),
		.reset        (reset),
		.valid_in     (valid_in),
		.pxl_in       (pxl_in),
		.replay_pxl   (replay_pxl),
		.replay_valid (replay_valid)
	);

	// Weights bypass the replay store
	window_conv i_window_conv (
		.clk             (clk),
		.reset           (reset),
		.valid_in        (replay_valid),
		.pxl_in          (replay_pxl),
		.valid_weight_in (valid_weight_in),
		.weight_in       (weight_in),
		.part_sum        (part_sum),
		.part_valid      (part_valid)
	);

	channel_accumulator i_channel_accumulator (
		.clk        (clk),
		.reset      (reset),
		.part_valid (part_valid),
		.part_sum   (part_sum),
		.chan_sum   (chan_sum),
		.chan_valid (chan_valid)
	);

	channel_interleaver i_channel_interleaver (
		.clk        (clk),
		.reset      (reset),
		.chan_valid (chan_valid),
		.chan_sum   (chan_sum),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out)
	);

endmodule

//--- logic/conv_pkg.sv
`include "conv_defs.svh"

package conv_pkg;

	//////////////////////////////////////////////////
	// Data words
	//////////////////////////////////////////////////

	typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
	typedef logic signed [`CONV_DATA_W-1:0] weight_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	//////////////////////////////////////////////////
	// State machines
	//////////////////////////////////////////////////

	// Frame store then replay per output channel
	typedef enum logic {
		RS_LOAD,
		RS_REPLAY
	} replay_state_t;

	// Plane collection then interleaved readout
	typedef enum logic {
		DS_FILL,
		DS_DRAIN
	} drain_state_t;

endpackage

//--- logic/feature_replay.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module feature_replay (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  conv_pkg::pixel_t pxl_in,
	output conv_pkg::pixel_t replay_pxl,
	output logic             replay_valid
);
	import conv_pkg::*;

	localparam int ADDR_W = $clog2(`CONV_FRAME);
	localparam int PASS_W = $clog2(`CONV_CH_OUT);

	pixel_t            frame_mem [0:`CONV_FRAME-1];
	logic [ADDR_W-1:0] wr_cnt;
	logic [ADDR_W-1:0] rd_cnt;
	logic [PASS_W-1:0] pass_cnt;
	replay_state_t     state;
	logic              wr_en;

	// Words arriving during replay are dropped
	assign wr_en = (state == RS_LOAD) && valid_in;

	//////////////////////////////////////////////////
	// Frame memory
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr_en) begin
			frame_mem[wr_cnt] <= pxl_in;
		end
	end

	always_ff @(posedge clk) begin
		replay_pxl <= frame_mem[rd_cnt];
	end

	//////////////////////////////////////////////////
	// Load / replay control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= RS_LOAD;
			wr_cnt       <= '0;
			rd_cnt       <= '0;
			pass_cnt     <= '0;
			replay_valid <= 1'b0;
		end else begin
			case (state)
				RS_LOAD: begin
					replay_valid <= 1'b0;
					if (valid_in) begin
						if (wr_cnt == ADDR_W'(`CONV_FRAME - 1)) begin
							wr_cnt <= '0;
							state  <= RS_REPLAY;
						end else begin
							wr_cnt <= wr_cnt + 1'b1;
						end
					end
				end
				RS_REPLAY: begin
					// One whole frame per output channel
					replay_valid <= 1'b1;
					if (rd_cnt == ADDR_W'(`CONV_FRAME - 1)) begin
						rd_cnt <= '0;
						if (pass_cnt == PASS_W'(`CONV_CH_OUT - 1)) begin
							pass_cnt <= '0;
							state    <= RS_LOAD;
						end else begin
							pass_cnt <= pass_cnt + 1'b1;
						end
					end else begin
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				default: state <= RS_LOAD;
			endcase
		end
	end

endmodule

//--- logic/window_conv.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module window_conv (
	input  logic              clk,
	input  logic              reset,
	input  logic              valid_in,
	input  conv_pkg::pixel_t  pxl_in,
	input  logic              valid_weight_in,
	input  conv_pkg::weight_t weight_in,
	output conv_pkg::acc_t    part_sum,
	output logic              part_valid
);
	import conv_pkg::*;

	localparam int KERNELS = `CONV_CH_IN * `CONV_CH_OUT;
	localparam int W_DEPTH = KERNELS * `CONV_TAPS;
	localparam int W_AW    = $clog2(W_DEPTH);
	localparam int COL_W   = $clog2(`CONV_IMG_W);
	localparam int ROW_W   = $clog2(`CONV_IMG_H);
	localparam int KSEL_W  = $clog2(KERNELS);

	weight_t           weight_mem [0:W_DEPTH-1];
	logic [W_AW-1:0]   w_wr_cnt;
	// Previous row and the row before it
	pixel_t            line_0 [0:`CONV_IMG_W-1];
	pixel_t            line_1 [0:`CONV_IMG_W-1];
	// Two older columns of the window, newest column comes from the lines
	pixel_t            win [0:2][0:1];
	pixel_t            taps [0:`CONV_TAPS-1];
	logic [COL_W-1:0]  col_cnt;
	logic [ROW_W-1:0]  row_cnt;
	logic [KSEL_W-1:0] plane_cnt;
	logic [W_AW-1:0]   w_base;
	logic              win_full;
	acc_t              prod [0:`CONV_TAPS-1];
	logic              prod_valid;
	acc_t              tap_sum;

	//////////////////////////////////////////////////
	// Weight memory
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (valid_weight_in) begin
			weight_mem[w_wr_cnt] <= weight_in;
		end
	end

	// Kernel of the plane currently streaming
	assign w_base = W_AW'(plane_cnt * `CONV_TAPS);

	//////////////////////////////////////////////////
	// Line buffers and window
	//////////////////////////////////////////////////

	// Taps row-major, row 0 is the oldest row
	always_comb begin
		for (int r = 0; r < 3; r++) begin
			taps[r*3]     = win[r][0];
			taps[r*3 + 1] = win[r][1];
		end
		taps[2] = line_1[col_cnt];
		taps[5] = line_0[col_cnt];
		taps[8] = pxl_in;
	end

	assign win_full = (row_cnt >= ROW_W'(2)) && (col_cnt >= COL_W'(2));

	always_ff @(posedge clk) begin
		if (valid_in) begin
			line_1[col_cnt] <= line_0[col_cnt];
			line_0[col_cnt] <= pxl_in;
			for (int r = 0; r < 3; r++) begin
				win[r][0] <= win[r][1];
				win[r][1] <= taps[r*3 + 2];
			end
		end
	end

	//////////////////////////////////////////////////
	// Multiply-add pipeline
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int k = 0; k < `CONV_TAPS; k++) begin
			prod[k] <= taps[k] * weight_mem[w_base + W_AW'(k)];
		end
	end

	always_comb begin
		tap_sum = '0;
		for (int k = 0; k < `CONV_TAPS; k++) begin
			tap_sum = tap_sum + prod[k];
		end
	end

	always_ff @(posedge clk) begin
		part_sum <= tap_sum;
	end

	// Counters and valid pipe
	always_ff @(posedge clk) begin
		if (reset) begin
			w_wr_cnt   <= '0;
			col_cnt    <= '0;
			row_cnt    <= '0;
			plane_cnt  <= '0;
			prod_valid <= 1'b0;
			part_valid <= 1'b0;
		end else begin
			if (valid_weight_in) begin
				if (w_wr_cnt == W_AW'(W_DEPTH - 1)) begin
					w_wr_cnt <= '0;
				end else begin
					w_wr_cnt <= w_wr_cnt + 1'b1;
				end
			end
			if (valid_in) begin
				if (col_cnt == COL_W'(`CONV_IMG_W - 1)) begin
					col_cnt <= '0;
					if (row_cnt == ROW_W'(`CONV_IMG_H - 1)) begin
						row_cnt <= '0;
						if (plane_cnt == KSEL_W'(KERNELS - 1)) begin
							plane_cnt <= '0;
						end else begin
							plane_cnt <= plane_cnt + 1'b1;
						end
					end else begin
						row_cnt <= row_cnt + 1'b1;
					end
				end else begin
					col_cnt <= col_cnt + 1'b1;
				end
			end
			prod_valid <= valid_in && win_full;
			part_valid <= prod_valid;
		end
	end

endmodule

//--- verification/conv_layer_tb.sv
`timescale 1ns/1ps
`include "conv_defs.svh"

module conv_layer_tb;
	import conv_pkg::*;

	localparam int N_WEIGHTS    = `CONV_CH_OUT * `CONV_CH_IN * `CONV_TAPS;
	localparam int OUT_WORDS    = `CONV_OUT_PLANE * `CONV_CH_OUT;
	localparam int MAX_IDLE     = 3;
	localparam int NUM_TESTS    = 6;
	localparam int FRAME_CYCLES = N_WEIGHTS + `CONV_FRAME + `CONV_CH_OUT * `CONV_FRAME + OUT_WORDS;
	localparam int GAP_CYCLES   = (N_WEIGHTS + `CONV_FRAME) * MAX_IDLE + 32;

	logic    clk;
	logic    reset;
	logic    valid_in;
	pixel_t  pxl_in;
	logic    valid_weight_in;
	weight_t weight_in;
	acc_t    pxl_out;
	logic    valid_out;

	pixel_t  frame [0:`CONV_FRAME-1];
	weight_t kernels [0:N_WEIGHTS-1];
	acc_t    expect_q [$];
	int      errors;
	int      start_errors;
	int      out_count;

	conv_layer_3x3 i_conv_layer_3x3 (
		.clk             (clk),
		.reset           (reset),
		.valid_in        (valid_in),
		.pxl_in          (pxl_in),
		.valid_weight_in (valid_weight_in),
		.weight_in       (weight_in),
		.pxl_out         (pxl_out),
		.valid_out       (valid_out)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Valid 3x3 correlation summed over input channels
	function automatic acc_t conv_ref(input int oc, input int y, input int x);
		int sum;
		int pix;
		int wt;
		sum = 0;
		for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
			for (int i = 0; i < 3; i++) begin
				for (int j = 0; j < 3; j++) begin
					pix = int'(frame[ic * `CONV_PLANE + (y + i) * `CONV_IMG_W + x + j]);
					wt  = int'(kernels[(oc * `CONV_CH_IN + ic) * `CONV_TAPS + i * 3 + j]);
					sum = sum + pix * wt;
				end
			end
		end
		return acc_t'(sum);
	endfunction

	// Output pixels row-major with all channels of a pixel together
	task automatic build_expected;
		for (int y = 0; y < `CONV_OUT_H; y++)
			for (int x = 0; x < `CONV_OUT_W; x++)
				for (int oc = 0; oc < `CONV_CH_OUT; oc++)
					expect_q.push_back(conv_ref(oc, y, x));
	endtask

	task automatic randomize_data;
		for (int k = 0; k < `CONV_FRAME; k++)
			frame[k] = pixel_t'($urandom);
		for (int k = 0; k < N_WEIGHTS; k++)
			kernels[k] = weight_t'($urandom);
	endtask

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s expected 0x%08h actual 0x%08h", name, expected, actual);
			errors++;
		end
	endtask

	always @(negedge clk) begin
		if (valid_out !== 1'b0) begin
			out_count++;
			if (expect_q.size() == 0) begin
				$display("Output word appeared with nothing expected at %0t", $time);
				errors++;
			end else begin
				check_value("pxl_out", expect_q.pop_front(), pxl_out);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic idle_gap(input int max_idle);
		int n;
		n = (max_idle > 0) ? $urandom_range(max_idle, 0) : 0;
		repeat (n) begin
			@(posedge clk);
			valid_in        <= 1'b0;
			valid_weight_in <= 1'b0;
		end
	endtask

	// Weights go ahead of the frame
	task automatic send_frame(input int max_idle);
		for (int k = 0; k < N_WEIGHTS; k++) begin
			idle_gap(max_idle);
			@(posedge clk);
			valid_weight_in <= 1'b1;
			weight_in       <= kernels[k];
		end
		@(posedge clk);
		valid_weight_in <= 1'b0;
		for (int k = 0; k < `CONV_FRAME; k++) begin
			idle_gap(max_idle);
			@(posedge clk);
			valid_in <= 1'b1;
			pxl_in   <= frame[k];
		end
		@(posedge clk);
		valid_in <= 1'b0;
	endtask

	task automatic wait_drained;
		int cycles;
		cycles = 0;
		while (expect_q.size() != 0 && cycles < FRAME_CYCLES + GAP_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (expect_q.size() != 0) begin
			$display("Frame did not drain, %0d output words never arrived", expect_q.size());
			errors++;
			expect_q.delete();
		end
		// Leave room for any stray extra word
		repeat (4) @(posedge clk);
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == start_errors)
			$display("Test %0d %s: ok", num, name);
		else
			$display("Test %0d %s: %0d errors", num, name, errors - start_errors);
		start_errors = errors;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		reset           = 1'b1;
		valid_in        = 1'b0;
		pxl_in          = '0;
		valid_weight_in = 1'b0;
		weight_in       = '0;
		errors          = 0;
		start_errors    = 0;
		out_count       = 0;
		void'($urandom(32'h73b0));

		repeat (8) @(posedge clk);
		reset <= 1'b0;
		repeat (16) @(posedge clk);
		report_test(1, "idle through reset");

		// Centre tap only gives the centre pixel summed over channels
		randomize_data();
		for (int k = 0; k < N_WEIGHTS; k++)
			kernels[k] = (k % `CONV_TAPS == 4) ? weight_t'(1) : weight_t'(0);
		for (int y = 0; y < `CONV_OUT_H; y++)
			for (int x = 0; x < `CONV_OUT_W; x++)
				for (int oc = 0; oc < `CONV_CH_OUT; oc++)
					expect_q.push_back(acc_t'(int'(frame[(y + 1) * `CONV_IMG_W + x + 1])
						+ int'(frame[`CONV_PLANE + (y + 1) * `CONV_IMG_W + x + 1])));
		send_frame(0);
		wait_drained();
		report_test(2, "identity kernels");

		randomize_data();
		build_expected();
		out_count = 0;
		send_frame(0);
		wait_drained();
		check_value("out_count", OUT_WORDS, out_count);
		report_test(3, "random frame");

		// Largest magnitude product in every tap
		for (int k = 0; k < `CONV_FRAME; k++)
			frame[k] = pixel_t'(-128);
		for (int k = 0; k < N_WEIGHTS; k++)
			kernels[k] = weight_t'(-128);
		repeat (OUT_WORDS) expect_q.push_back(acc_t'(18 * 16384));
		send_frame(0);
		wait_drained();
		report_test(4, "full scale negative");

		randomize_data();
		build_expected();
		send_frame(MAX_IDLE);
		wait_drained();
		report_test(5, "idle gaps in input");

		for (int f = 0; f < 2; f++) begin
			randomize_data();
			build_expected();
			send_frame(0);
			wait_drained();
		end
		report_test(6, "two frames");

		$display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		#(NUM_TESTS * (FRAME_CYCLES + GAP_CYCLES) * 2 * 100);
		$display("Watchdog expired before all tests finished");
		$display("test failed");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+logic
logic/conv_pkg.sv
logic/feature_replay.sv
logic/window_conv.sv
logic/channel_accumulator.sv
logic/channel_interleaver.sv
logic/conv_layer_3x3.sv
verification/conv_layer_tb.sv
